// File: Bender.yml
package:
  name: wisc_pipe

sources:
  - wisc_pkg.sv
  - wisc_ifs.sv
  - wisc_regfile.sv
  - wisc_decode.sv
  - wisc_execute.sv
  - wisc_pipe.sv
  - target: test
    files:
      - wisc_pipe_chk.sv
      - tb_wisc_pipe.sv

// File: build.f
wisc_pkg.sv
wisc_ifs.sv
wisc_regfile.sv
wisc_decode.sv
wisc_execute.sv
wisc_pipe.sv
wisc_pipe_chk.sv
tb_wisc_pipe.sv

// File: tb_wisc_pipe.sv
// testbench for the two-stage WISC datapath with LFSR stimulus,
// register model and write-back checks
`timescale 1ns/100ps
`default_nettype none

module tb_wisc_pipe;
   import wisc_pkg::*;

   localparam logic [31:0] SEED = 32'h6ca6f212;
   localparam int DRAIN_LIMIT = 20;

   logic     clk;
   logic     rst_n;
   logic     instr_valid;
   word_t    instr;
   logic     wb_valid;
   reg_idx_t wb_reg;
   word_t    wb_data;
   logic     err;

   logic [31:0] lfsr;
   int          cyc = 0;
   int          errors = 0;
   int          checks = 0;
   string       test_name;
   word_t       model_regs [NUM_REGS];
   reg_idx_t    exp_reg_q [$];
   word_t       exp_data_q [$];
   int          exp_cyc_q [$];
   reg_idx_t    e_reg;
   word_t       e_data;
   int          e_cyc;

   op_t alu_ops [7] = '{OP_ADD, OP_SUB, OP_XOR, OP_ANDN, OP_ADDI, OP_SEQ, OP_SLT};
   op_t all_ops [9] = '{OP_ADD, OP_SUB, OP_XOR, OP_ANDN, OP_ADDI, OP_SEQ, OP_SLT,
                        OP_LBI, OP_SLBI};

   wisc_pipe u_dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .wb_valid    (wb_valid),
      .wb_reg      (wb_reg),
      .wb_data     (wb_data),
      .err         (err)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         val = {val[30:0], lfsr[0]};
      end
      return val;
   endfunction

   function automatic logic is_legal(input logic [4:0] opc);
      case (opc)
         OP_ADD, OP_SUB, OP_XOR, OP_ANDN, OP_ADDI, OP_LBI, OP_SLBI, OP_SEQ, OP_SLT:
            return 1'b1;
         default:
            return 1'b0;
      endcase
   endfunction

   // result per the operation table
   function automatic word_t model_result(input op_t op, input word_t a, input word_t b,
                                          input word_t old_rd, input imm8_t imm8);
      case (op)
         OP_ADD:  return a + b;
         OP_SUB:  return a - b;
         OP_XOR:  return a ^ b;
         OP_ANDN: return a & ~b;
         OP_ADDI: return a + {{11{imm8[4]}}, imm8[4:0]};
         OP_LBI:  return {{8{imm8[7]}}, imm8};
         OP_SLBI: return {old_rd[7:0], imm8};
         OP_SEQ:  return (a == b) ? 16'd1 : 16'd0;
         OP_SLT:  return ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
         default: return 16'hxxxx;
      endcase
   endfunction

   task automatic send_instr(input op_t op, input reg_idx_t rd, input reg_idx_t rs,
                             input reg_idx_t rt, input imm8_t imm8);
      word_t word;
      word_t res;
      case (op)
         OP_ADDI:         word = {op, rd, rs, imm8[4:0]};
         OP_LBI, OP_SLBI: word = {op, rd, imm8};
         default:         word = {op, rd, rs, rt, 2'b00};
      endcase
      res = model_result(op, model_regs[rs], model_regs[rt], model_regs[rd], imm8);
      @(negedge clk);
      instr_valid = 1'b1;
      instr       = word;
      model_regs[rd] = res;
      exp_reg_q.push_back(rd);
      exp_data_q.push_back(res);
      exp_cyc_q.push_back(cyc + 2);
   endtask

   // register fields from the low 2**reg_bits registers
   task automatic send_random(input op_t op, input int reg_bits);
      reg_idx_t rd;
      reg_idx_t rs;
      reg_idx_t rt;
      imm8_t    imm8;
      rd   = reg_idx_t'(rand_bits(reg_bits));
      rs   = reg_idx_t'(rand_bits(reg_bits));
      rt   = reg_idx_t'(rand_bits(reg_bits));
      imm8 = imm8_t'(rand_bits(8));
      send_instr(op, rd, rs, rt, imm8);
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge clk);
         instr_valid = 1'b0;
      end
   endtask

   task automatic drain_and_check_err(input logic exp_err);
      int t;
      idle(1);
      t = 0;
      while (exp_reg_q.size() != 0 && t < DRAIN_LIMIT) begin
         @(negedge clk);
         t++;
      end
      if (exp_reg_q.size() != 0) begin
         errors++;
         $display("%s: timed out with %0d write-backs still missing", test_name,
                  exp_reg_q.size());
         exp_reg_q.delete();
         exp_data_q.delete();
         exp_cyc_q.delete();
      end
      if (err !== exp_err) begin
         errors++;
         $display("MISMATCH %s err expected %b actual %b", test_name, exp_err, err);
      end
   endtask

   // write-back monitor on the falling edge
   always @(negedge clk) begin
      if (rst_n && wb_valid) begin
         if (exp_reg_q.size() == 0) begin
            errors++;
            $display("%s: write-back to r%0d with no instruction outstanding",
                     test_name, wb_reg);
         end else begin
            e_reg  = exp_reg_q.pop_front();
            e_data = exp_data_q.pop_front();
            e_cyc  = exp_cyc_q.pop_front();
            checks++;
            if (wb_reg !== e_reg) begin
               errors++;
               $display("MISMATCH %s wb_reg expected %0d actual %0d", test_name, e_reg, wb_reg);
            end
            if (wb_data !== e_data) begin
               errors++;
               $display("MISMATCH %s wb_data expected %h actual %h", test_name, e_data, wb_data);
            end
            if (cyc != e_cyc) begin
               errors++;
               $display("MISMATCH %s latency expected %0d actual %0d", test_name, e_cyc, cyc);
            end
         end
      end
   end

   initial begin
      logic [4:0]  bad_opc;
      logic [31:0] filler;
      reg_idx_t    rd;
      lfsr        = SEED;
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr       = '0;
      test_name   = "reset";
      for (int i = 0; i < NUM_REGS; i++) begin
         model_regs[i] = '0;
      end
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      if (wb_valid !== 1'b0 || err !== 1'b0) begin
         errors++;
         $display("reset: wb_valid or err not low after reset");
      end
      for (int i = 0; i < NUM_REGS; i++) begin
         send_instr(OP_ADD, reg_idx_t'(i), reg_idx_t'(i), reg_idx_t'(i), '0);
      end
      drain_and_check_err(1'b0);

      test_name = "alu_set";
      for (int n = 0; n < 60; n++) begin
         send_random(alu_ops[rand_bits(3) % 7], 2);
         idle(rand_bits(2));
      end
      drain_and_check_err(1'b0);

      test_name = "byte_loads";
      for (int n = 0; n < 8; n++) begin
         rd = reg_idx_t'(rand_bits(3));
         send_instr(OP_LBI, rd, '0, '0, imm8_t'(rand_bits(8)));
         send_instr(OP_SLBI, rd, '0, '0, imm8_t'(rand_bits(8)));
         idle(rand_bits(1));
      end
      drain_and_check_err(1'b0);

      test_name = "back_to_back";
      for (int n = 0; n < 100; n++) begin
         send_random(all_ops[rand_bits(4) % 9], 1);
      end
      drain_and_check_err(1'b0);

      test_name = "illegal";
      bad_opc = 5'b00000;
      for (int t = 0; t < 32; t++) begin
         bad_opc = 5'(rand_bits(5));
         if (!is_legal(bad_opc))
            break;
      end
      filler = rand_bits(11);
      @(negedge clk);
      instr_valid = 1'b1;
      instr       = {bad_opc, filler[10:0]};
      idle(1);
      if (err !== 1'b1) begin
         errors++;
         $display("illegal: err did not rise after an illegal opcode");
      end
      for (int n = 0; n < 20; n++) begin
         send_random(all_ops[rand_bits(4) % 9], 1);
      end
      drain_and_check_err(1'b1);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: wisc_decode.sv
// decode stage with field split, opcode check, immediate extension
// and the decode/execute register
`timescale 1ns/100ps
`default_nettype none

module wisc_decode (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            instr_valid,
   input  wisc_pkg::word_t instr,
   rf_read_if.requester    rd_port,
   id_ex_if.source         id_ex,
   output logic            err
);
   import wisc_pkg::*;

   logic [OPC_W-1:0]  opcode;
   reg_idx_t          rd;
   reg_idx_t          rs;
   reg_idx_t          rt;
   logic [IMM5_W-1:0] imm5;
   imm8_t             imm8;
   logic              legal;
   word_t             imm;

   assign opcode = instr[OPC_MSB -: OPC_W];
   assign rd     = instr[RD_MSB -: REG_W];
   assign rs     = instr[RS_MSB -: REG_W];
   assign rt     = instr[RT_MSB -: REG_W];
   assign imm5   = instr[IMM5_MSB -: IMM5_W];
   assign imm8   = instr[IMM8_MSB -: IMM8_W];

   // opcode check and immediate forming
   always_comb begin
      legal = 1'b1;
      imm   = '0;
      case (opcode)
         OP_ADD, OP_SUB, OP_XOR, OP_ANDN, OP_SEQ, OP_SLT: begin
            imm = '0;
         end
         OP_ADDI: begin
            imm = {{(WORD_W-IMM5_W){imm5[IMM5_W-1]}}, imm5};
         end
         OP_LBI: begin
            imm = {{(WORD_W-IMM8_W){imm8[IMM8_W-1]}}, imm8};
         end
         OP_SLBI: begin
            imm = {{(WORD_W-IMM8_W){1'b0}}, imm8};
         end
         default: begin
            legal = 1'b0;
         end
      endcase
   end

   // slbi shifts the old rd, so read rd on port a
   assign rd_port.a_idx = (opcode == OP_SLBI) ? rd : rs;
   assign rd_port.b_idx = rt;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         id_ex.valid <= 1'b0;
         err         <= 1'b0;
      end else begin
         id_ex.valid <= instr_valid & legal;
         // sticky until reset
         if (instr_valid && !legal)
            err <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      id_ex.op    <= op_t'(opcode);
      id_ex.rd    <= rd;
      id_ex.a_idx <= rd_port.a_idx;
      id_ex.b_idx <= rd_port.b_idx;
      id_ex.a_val <= rd_port.a_data;
      id_ex.b_val <= rd_port.b_data;
      id_ex.imm   <= imm;
   end

endmodule

`default_nettype wire

// File: wisc_execute.sv
// execute stage with operand forwarding, ALU and set logic,
// and the write-back register
`timescale 1ns/100ps
`default_nettype none

module wisc_execute (
   input  logic                clk,
   input  logic                rst_n,
   id_ex_if.sink               id_ex,
   output logic                wr_en,
   output wisc_pkg::reg_idx_t  wr_idx,
   output wisc_pkg::word_t     wr_data
);
   import wisc_pkg::*;

   word_t a_op;
   word_t b_op;
   word_t result;
   logic  a_fwd;
   logic  b_fwd;

   // write-back register holds the result the rf has not stored yet
   assign a_fwd = wr_en && (wr_idx == id_ex.a_idx);
   assign b_fwd = wr_en && (wr_idx == id_ex.b_idx);
   assign a_op  = a_fwd ? wr_data : id_ex.a_val;
   assign b_op  = b_fwd ? wr_data : id_ex.b_val;

   always_comb begin
      result = '0;
      case (id_ex.op)
         OP_ADD: begin
            result = a_op + b_op;
         end
         OP_SUB: begin
            result = a_op - b_op;
         end
         OP_XOR: begin
            result = a_op ^ b_op;
         end
         OP_ANDN: begin
            result = a_op & ~b_op;
         end
         OP_ADDI: begin
            result = a_op + id_ex.imm;
         end
         OP_LBI: begin
            result = id_ex.imm;
         end
         OP_SLBI: begin
            // a holds the old rd here
            result = (a_op << IMM8_W) | id_ex.imm;
         end
         OP_SEQ: begin
            result = word_t'(a_op == b_op);
         end
         OP_SLT: begin
            result = word_t'($signed(a_op) < $signed(b_op));
         end
         default: begin
            result = '0;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_en <= 1'b0;
      end else begin
         wr_en <= id_ex.valid;
      end
   end

   always_ff @(posedge clk) begin
      wr_idx  <= id_ex.rd;
      wr_data <= result;
   end

endmodule

`default_nettype wire

// File: wisc_ifs.sv
// register-file read interface and decode/execute boundary interface
`timescale 1ns/100ps
`default_nettype none

interface rf_read_if;
   import wisc_pkg::*;

   reg_idx_t a_idx;
   reg_idx_t b_idx;
   word_t    a_data;
   word_t    b_data;

   modport requester (output a_idx, output b_idx, input a_data, input b_data);
   modport responder (input a_idx, input b_idx, output a_data, output b_data);
endinterface

interface id_ex_if;
   import wisc_pkg::*;

   logic     valid;
   op_t      op;
   reg_idx_t rd;
   reg_idx_t a_idx;
   reg_idx_t b_idx;
   word_t    a_val;
   word_t    b_val;
   word_t    imm;

   modport source (output valid, op, rd, a_idx, b_idx, a_val, b_val, imm);
   modport sink (input valid, op, rd, a_idx, b_idx, a_val, b_val, imm);
endinterface

`default_nettype wire

// File: wisc_pipe.sv
// two-stage WISC datapath top level, decode, register file and execute
`timescale 1ns/100ps
`default_nettype none

module wisc_pipe (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               instr_valid,
   input  wisc_pkg::word_t    instr,
   output logic               wb_valid,
   output wisc_pkg::reg_idx_t wb_reg,
   output wisc_pkg::word_t    wb_data,
   output logic               err
);
   import wisc_pkg::*;

   logic     wr_en;
   reg_idx_t wr_idx;
   word_t    wr_data;

   rf_read_if rf_rd ();
   id_ex_if   id_ex ();

   wisc_decode u_decode (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_valid (instr_valid),
      .instr       (instr),
      .rd_port     (rf_rd.requester),
      .id_ex       (id_ex.source),
      .err         (err)
   );

   wisc_regfile u_regfile (
      .clk     (clk),
      .rst_n   (rst_n),
      .rd_port (rf_rd.responder),
      .wr_en   (wr_en),
      .wr_idx  (wr_idx),
      .wr_data (wr_data)
   );

   wisc_execute u_execute (
      .clk     (clk),
      .rst_n   (rst_n),
      .id_ex   (id_ex.sink),
      .wr_en   (wr_en),
      .wr_idx  (wr_idx),
      .wr_data (wr_data)
   );

   // write port doubles as the visible write-back
   assign wb_valid = wr_en;
   assign wb_reg   = wr_idx;
   assign wb_data  = wr_data;

endmodule

`default_nettype wire

// File: wisc_pipe_chk.sv
// concurrent assertions on the datapath top level, bound to wisc_pipe
`timescale 1ns/100ps
`default_nettype none

module wisc_pipe_chk (
   input logic            clk,
   input logic            rst_n,
   input logic            instr_valid,
   input logic            wb_valid,
   input wisc_pkg::word_t wb_data,
   input logic            err
);

   // fixed two-edge latency from strobe to write-back
   a_wb_has_source: assert property (@(posedge clk) disable iff (!rst_n)
      wb_valid |-> $past(instr_valid, 2))
      else $error("write-back without an instruction two cycles earlier");

   a_err_sticky: assert property (@(posedge clk) disable iff (!rst_n) !$fell(err))
      else $error("err fell while out of reset");

   a_wb_known: assert property (@(posedge clk) disable iff (!rst_n)
      wb_valid |-> !$isunknown(wb_data))
      else $error("write-back data has unknown bits");

endmodule

bind wisc_pipe wisc_pipe_chk u_chk (
   .clk         (clk),
   .rst_n       (rst_n),
   .instr_valid (instr_valid),
   .wb_valid    (wb_valid),
   .wb_data     (wb_data),
   .err         (err)
);

`default_nettype wire

// File: wisc_pkg.sv
// WISC package with data and index types, instruction field positions
// and the opcode encoding
`default_nettype none

package wisc_pkg;

   localparam int WORD_W   = 16;
   localparam int REG_W    = 3;
   localparam int NUM_REGS = 8;

   // field positions as top bit and width
   localparam int OPC_MSB  = 15;
   localparam int OPC_W    = 5;
   localparam int RD_MSB   = 10;
   localparam int RS_MSB   = 7;
   localparam int RT_MSB   = 4;
   localparam int IMM5_MSB = 4;
   localparam int IMM5_W   = 5;
   localparam int IMM8_MSB = 7;
   localparam int IMM8_W   = 8;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [REG_W-1:0]  reg_idx_t;
   typedef logic [IMM8_W-1:0] imm8_t;

   // every other 5-bit value traps
   typedef enum logic [OPC_W-1:0] {
      OP_ADDI = 5'b01000,
      OP_SLBI = 5'b10010,
      OP_LBI  = 5'b11000,
      OP_SUB  = 5'b11001,
      OP_XOR  = 5'b11010,
      OP_ADD  = 5'b11011,
      OP_SEQ  = 5'b11100,
      OP_SLT  = 5'b11101,
      OP_ANDN = 5'b11111
   } op_t;

endpackage

`default_nettype wire

// File: wisc_regfile.sv
// eight-entry register file, two read ports with write-through bypass
`timescale 1ns/100ps
`default_nettype none

module wisc_regfile (
   input  logic               clk,
   input  logic               rst_n,
   rf_read_if.responder       rd_port,
   input  logic               wr_en,
   input  wisc_pkg::reg_idx_t wr_idx,
   input  wisc_pkg::word_t    wr_data
);
   import wisc_pkg::*;

   word_t regs [NUM_REGS];

   // pending write wins over the stored value
   function automatic word_t read_bypass(input reg_idx_t idx);
      word_t val;
      val = regs[idx];
      if (wr_en && (wr_idx == idx))
         val = wr_data;
      return val;
   endfunction

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_idx] <= wr_data;
      end
   end

   always_comb begin
      rd_port.a_data = read_bypass(rd_port.a_idx);
      rd_port.b_data = read_bypass(rd_port.b_idx);
   end

endmodule

`default_nettype wire
